/* source/dsp_pkg.sv */
/*
 * Shared widths, client count, opcode values, grant quantum and the
 * arbiter state codes for the DSP multiply subsystem.
 */

package dsp_pkg;

    localparam int CLIENTS_N = 2;   // Clients sharing the slice.

    localparam int OP_W = 8;        // Opcode width.
    localparam int AB_W = 18;       // Multiplier operand width, signed.
    localparam int CP_W = 48;       // Addend and result width, signed.

    // Cycles a client may hold the grant while the other one waits.
    localparam int QUANTUM = 4;
    localparam int CNT_W   = 3;     // Grant timer width.

    // Opcodes, unknown values behave as OP_NOP.
    localparam logic [OP_W-1:0] OP_NOP  = 8'h00;  // Idle.
    localparam logic [OP_W-1:0] OP_MUL  = 8'h01;  // p = a * b.
    localparam logic [OP_W-1:0] OP_MAC  = 8'h02;  // p = c + a * b.
    localparam logic [OP_W-1:0] OP_MSU  = 8'h03;  // p = c - a * b.
    localparam logic [OP_W-1:0] OP_PASS = 8'h04;  // p = c.

    // Arbiter states are one-hot on the owner, so the state is the grant.
    localparam logic [CLIENTS_N-1:0] IDLE   = 2'b00;
    localparam logic [CLIENTS_N-1:0] GRANT0 = 2'b01;
    localparam logic [CLIENTS_N-1:0] GRANT1 = 2'b10;

endpackage

/* source/dsp_lane_if.sv */
/*
 * One DSP lane between the interconnect and the slice: opcode,
 * operands, addend and result.
 */

`timescale 1ns/100ps

interface dsp_lane_if;
    import dsp_pkg::*;

    logic        [OP_W-1:0] op;    // Zero when the lane is idle.
    logic signed [AB_W-1:0] a;     // Multiplicand.
    logic signed [AB_W-1:0] b;     // Multiplier.
    logic signed [CP_W-1:0] c;     // Addend.
    logic signed [CP_W-1:0] p;     // Result, two edges after issue.

    // Interconnect side.
    modport client (
        output op, a, b, c,
        input  p
    );

    // Slice side.
    modport slice (
        input  op, a, b, c,
        output p
    );

endinterface

/* source/arb_rr.sv */
/*
 * Round-robin arbiter FSM for two clients, with grant start pulse
 * and preemption on timer expiry.
 */

`timescale 1ns/100ps

module arb_rr (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [dsp_pkg::CLIENTS_N-1:0] req,
    input  logic                          expired,
    output logic [dsp_pkg::CLIENTS_N-1:0] gnt,
    output logic                          new_grant
);
    import dsp_pkg::*;

    logic [CLIENTS_N-1:0] state;       // One-hot owner, zero when idle.
    logic [CLIENTS_N-1:0] state_nx;
    logic                 last_owner;  // Client that held the last grant.

    always_comb begin
        state_nx = state;
        case (state)
            IDLE: begin
                if (req[0] && req[1]) begin
                    // Tie goes to the client after the last owner.
                    state_nx = last_owner ? GRANT0 : GRANT1;
                end else if (req[0]) begin
                    state_nx = GRANT0;
                end else if (req[1]) begin
                    state_nx = GRANT1;
                end
            end
            GRANT0: begin
                if (!req[0]) begin
                    state_nx = req[1] ? GRANT1 : IDLE;  // Released.
                end else if (expired && req[1]) begin
                    state_nx = GRANT1;                  // Quantum used up.
                end
            end
            GRANT1: begin
                if (!req[1]) begin
                    state_nx = req[0] ? GRANT0 : IDLE;
                end else if (expired && req[0]) begin
                    state_nx = GRANT0;
                end
            end
            default: begin
                state_nx = IDLE;
            end
        endcase
    end

    // Pulses on the cycle before a new grant shows on gnt.
    assign new_grant = (state_nx != state) && (state_nx != IDLE);

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= IDLE;
            last_owner <= 1'b1;  // So client 0 wins the first tie.
        end else begin
            state <= state_nx;
            if (state_nx == GRANT0) begin
                last_owner <= 1'b0;
            end else if (state_nx == GRANT1) begin
                last_owner <= 1'b1;
            end
        end
    end

    assign gnt = state;  // Registered grant.

endmodule

/* source/grant_timer.sv */
/*
 * Saturating grant age counter, flags when the current grant
 * has lasted a full quantum.
 */

`timescale 1ns/100ps

module grant_timer (
    input  logic clk,
    input  logic rst,
    input  logic new_grant,
    output logic expired
);
    import dsp_pkg::*;

    logic [CNT_W-1:0] cnt;  // Grant cycles held, minus one.

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt <= '0;
        end else if (new_grant) begin
            cnt <= '0;  // First cycle of the grant reads zero.
        end else if (!expired) begin
            cnt <= cnt + 1'b1;
        end
    end

    // High on the QUANTUM-th grant cycle, then held.
    assign expired = (cnt == CNT_W'(QUANTUM - 1));

endmodule

/* source/dsp_nic_mul.sv */
/*
 * Client to slice interconnect: operand mux for the granted client,
 * owner tag pipeline and result steering with done pulses.
 */

`timescale 1ns/100ps

module dsp_nic_mul (
    input  logic                               clk,
    input  logic                               rst,
    input  logic        [dsp_pkg::CLIENTS_N-1:0] gnt,
    input  logic        [dsp_pkg::OP_W-1:0]    client_op [dsp_pkg::CLIENTS_N],
    input  logic signed [dsp_pkg::AB_W-1:0]    client_al [dsp_pkg::CLIENTS_N],
    input  logic signed [dsp_pkg::AB_W-1:0]    client_bl [dsp_pkg::CLIENTS_N],
    input  logic signed [dsp_pkg::CP_W-1:0]    client_cl [dsp_pkg::CLIENTS_N],
    input  logic signed [dsp_pkg::AB_W-1:0]    client_ar [dsp_pkg::CLIENTS_N],
    input  logic signed [dsp_pkg::AB_W-1:0]    client_br [dsp_pkg::CLIENTS_N],
    input  logic signed [dsp_pkg::CP_W-1:0]    client_cr [dsp_pkg::CLIENTS_N],
    output logic signed [dsp_pkg::CP_W-1:0]    client_pl [dsp_pkg::CLIENTS_N],
    output logic signed [dsp_pkg::CP_W-1:0]    client_pr [dsp_pkg::CLIENTS_N],
    output logic        [dsp_pkg::CLIENTS_N-1:0] done,
    output logic                               issue,
    dsp_lane_if.client                         left,
    dsp_lane_if.client                         right
);
    import dsp_pkg::*;

    logic [1:0]           valid_q;   // Op in slice stage one and two.
    logic [CLIENTS_N-1:0] tag_q [2]; // One-hot issuing client per stage.

    // At most one gnt bit is set, so the loop is a plain mux.
    always_comb begin
        left.op  = OP_NOP;
        left.a   = '0;
        left.b   = '0;
        left.c   = '0;
        right.op = OP_NOP;
        right.a  = '0;
        right.b  = '0;
        right.c  = '0;
        for (int i = 0; i < CLIENTS_N; i++) begin
            if (gnt[i]) begin
                left.op  = client_op[i];  // Both lanes share the opcode.
                left.a   = client_al[i];
                left.b   = client_bl[i];
                left.c   = client_cl[i];
                right.op = client_op[i];
                right.a  = client_ar[i];
                right.b  = client_br[i];
                right.c  = client_cr[i];
            end
        end
    end

    assign issue = (left.op != OP_NOP);

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 2'b00;
        end else begin
            valid_q <= {valid_q[0], issue};
        end
    end

    // Owner tag follows the op through the slice.
    always_ff @(posedge clk) begin
        tag_q[0] <= gnt;
        tag_q[1] <= tag_q[0];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            done <= '0;
            for (int i = 0; i < CLIENTS_N; i++) begin
                client_pl[i] <= '0;
                client_pr[i] <= '0;
            end
        end else begin
            done <= valid_q[1] ? tag_q[1] : '0;
            for (int i = 0; i < CLIENTS_N; i++) begin
                if (valid_q[1] && tag_q[1][i]) begin
                    client_pl[i] <= left.p;  // Other client keeps its result.
                    client_pr[i] <= right.p;
                end
            end
        end
    end

endmodule

/* source/dsp_slice.sv */
/*
 * Dual-lane multiply-add slice, two pipeline stages:
 * input registers, then product and add, subtract or pass.
 */

`timescale 1ns/100ps

module dsp_slice (
    input  logic       clk,
    input  logic       rst,
    input  logic       issue,
    dsp_lane_if.slice  left,
    dsp_lane_if.slice  right
);
    import dsp_pkg::*;

    // Index 0 is the left lane, 1 the right lane.
    logic        [OP_W-1:0] op_q [2];
    logic signed [AB_W-1:0] a_q  [2];
    logic signed [AB_W-1:0] b_q  [2];
    logic signed [CP_W-1:0] c_q  [2];
    logic                   v1;        // Stage one holds an op.

    // Result of one lane for a given opcode.
    function automatic logic signed [CP_W-1:0] lane_calc(
        input logic        [OP_W-1:0] op,
        input logic signed [AB_W-1:0] a,
        input logic signed [AB_W-1:0] b,
        input logic signed [CP_W-1:0] c
    );
        logic signed [CP_W-1:0] prod;
        logic signed [CP_W-1:0] res;

        prod = CP_W'(a) * CP_W'(b);  // Sign extended, full 36-bit product.
        case (op)
            OP_MUL:  res = prod;
            OP_MAC:  res = c + prod;
            OP_MSU:  res = c - prod;
            OP_PASS: res = c;
            default: res = '0;        // NOP and unknown codes.
        endcase
        return res;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            v1 <= 1'b0;
        end else begin
            v1 <= issue;
        end
    end

    // Stage one, loaded only on issue.
    always_ff @(posedge clk) begin
        if (issue) begin
            op_q[0] <= left.op;
            a_q[0]  <= left.a;
            b_q[0]  <= left.b;
            c_q[0]  <= left.c;
            op_q[1] <= right.op;
            a_q[1]  <= right.a;
            b_q[1]  <= right.b;
            c_q[1]  <= right.c;
        end
    end

    // Stage two, p holds until the next op completes.
    always_ff @(posedge clk) begin
        if (v1) begin
            left.p  <= lane_calc(op_q[0], a_q[0], b_q[0], c_q[0]);
            right.p <= lane_calc(op_q[1], a_q[1], b_q[1], c_q[1]);
        end
    end

endmodule

/* source/dsp_mul_top.sv */
/*
 * Shared DSP multiply subsystem: arbiter, grant timer,
 * interconnect and dual-lane slice.
 */

`timescale 1ns/100ps

module dsp_mul_top (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic        [dsp_pkg::CLIENTS_N-1:0] req,
    output logic        [dsp_pkg::CLIENTS_N-1:0] gnt,
    input  logic        [dsp_pkg::OP_W-1:0]      client_op [dsp_pkg::CLIENTS_N],
    input  logic signed [dsp_pkg::AB_W-1:0]      client_al [dsp_pkg::CLIENTS_N],
    input  logic signed [dsp_pkg::AB_W-1:0]      client_bl [dsp_pkg::CLIENTS_N],
    input  logic signed [dsp_pkg::AB_W-1:0]      client_ar [dsp_pkg::CLIENTS_N],
    input  logic signed [dsp_pkg::AB_W-1:0]      client_br [dsp_pkg::CLIENTS_N],
    input  logic signed [dsp_pkg::CP_W-1:0]      client_cl [dsp_pkg::CLIENTS_N],
    input  logic signed [dsp_pkg::CP_W-1:0]      client_cr [dsp_pkg::CLIENTS_N],
    output logic signed [dsp_pkg::CP_W-1:0]      client_pl [dsp_pkg::CLIENTS_N],
    output logic signed [dsp_pkg::CP_W-1:0]      client_pr [dsp_pkg::CLIENTS_N],
    output logic        [dsp_pkg::CLIENTS_N-1:0] done
);

    logic new_grant;   // Arbiter is about to hand out a grant.
    logic expired;     // Current grant has used its quantum.
    logic issue;       // Granted client presents an op this cycle.

    dsp_lane_if lane_l ();
    dsp_lane_if lane_r ();

    arb_rr u_arb (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .expired   (expired),
        .gnt       (gnt),
        .new_grant (new_grant)
    );

    grant_timer u_timer (
        .clk       (clk),
        .rst       (rst),
        .new_grant (new_grant),
        .expired   (expired)
    );

    // Routes operands in and results back by owner tag.
    dsp_nic_mul u_nic (
        .clk       (clk),
        .rst       (rst),
        .gnt       (gnt),
        .client_op (client_op),
        .client_al (client_al),
        .client_bl (client_bl),
        .client_cl (client_cl),
        .client_ar (client_ar),
        .client_br (client_br),
        .client_cr (client_cr),
        .client_pl (client_pl),
        .client_pr (client_pr),
        .done      (done),
        .issue     (issue),
        .left      (lane_l.client),
        .right     (lane_r.client)
    );

    dsp_slice u_slice (
        .clk   (clk),
        .rst   (rst),
        .issue (issue),
        .left  (lane_l.slice),
        .right (lane_r.slice)
    );

endmodule

/* testbench/tb_clock.sv */
/*
 * Free-running testbench clock, 100 ns period.
 */

`timescale 1ns/100ps

module tb_clock (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;  // Half period.
        end
    end

endmodule

/* testbench/dsp_mul_asserts.sv */
/*
 * Concurrent checks on the DSP multiply top level: reset values,
 * round-robin grant and quantum, result routing and lane arithmetic.
 */

`timescale 1ns/100ps

module dsp_mul_asserts (
    input logic                                 clk,
    input logic                                 rst,
    input logic        [dsp_pkg::CLIENTS_N-1:0] req,
    input logic        [dsp_pkg::CLIENTS_N-1:0] gnt,
    input logic        [dsp_pkg::OP_W-1:0]      client_op [dsp_pkg::CLIENTS_N],
    input logic signed [dsp_pkg::AB_W-1:0]      client_al [dsp_pkg::CLIENTS_N],
    input logic signed [dsp_pkg::AB_W-1:0]      client_bl [dsp_pkg::CLIENTS_N],
    input logic signed [dsp_pkg::AB_W-1:0]      client_ar [dsp_pkg::CLIENTS_N],
    input logic signed [dsp_pkg::AB_W-1:0]      client_br [dsp_pkg::CLIENTS_N],
    input logic signed [dsp_pkg::CP_W-1:0]      client_cl [dsp_pkg::CLIENTS_N],
    input logic signed [dsp_pkg::CP_W-1:0]      client_cr [dsp_pkg::CLIENTS_N],
    input logic signed [dsp_pkg::CP_W-1:0]      client_pl [dsp_pkg::CLIENTS_N],
    input logic signed [dsp_pkg::CP_W-1:0]      client_pr [dsp_pkg::CLIENTS_N],
    input logic        [dsp_pkg::CLIENTS_N-1:0] done
);
    import dsp_pkg::*;

    int                     fail_count = 0;  // Read by the testbench top.
    logic                   last_owner;      // Owner of the latest grant.
    logic [CLIENTS_N-1:0]   idle_win;        // Next gnt when none is held.
    logic [CLIENTS_N-1:0]   idle_win_q;
    logic [CLIENTS_N-1:0]   gnt_d;
    int                     held_d;
    int                     held;            // Cycles the current gnt has lasted.
    logic [CLIENTS_N-1:0]   iss;             // Operation accepted this cycle.
    logic [CLIENTS_N-1:0]   iss_q [3];
    logic signed [CP_W-1:0] exp_l;
    logic signed [CP_W-1:0] exp_r;
    logic signed [CP_W-1:0] exp_l_q [3];
    logic signed [CP_W-1:0] exp_r_q [3];

    // Lane result in 64-bit arithmetic, kept to the result width.
    function automatic logic signed [CP_W-1:0] expect_result(
        input logic        [OP_W-1:0] op,
        input logic signed [AB_W-1:0] a,
        input logic signed [AB_W-1:0] b,
        input logic signed [CP_W-1:0] c
    );
        longint prod;
        longint sum;

        prod = longint'(a) * longint'(b);
        if (op == OP_MUL) sum = prod;
        else if (op == OP_MAC) sum = longint'(c) + prod;
        else if (op == OP_MSU) sum = longint'(c) - prod;
        else if (op == OP_PASS) sum = longint'(c);
        else sum = 0;
        return sum[CP_W-1:0];
    endfunction

    always_comb begin
        case (req)
            2'b01:   idle_win = 2'b01;
            2'b10:   idle_win = 2'b10;
            2'b11:   idle_win = last_owner ? 2'b01 : 2'b10;  // Next after last owner.
            default: idle_win = 2'b00;
        endcase
    end

    always_comb begin
        iss   = '0;
        exp_l = '0;
        exp_r = '0;
        for (int i = 0; i < CLIENTS_N; i++) begin
            if (gnt[i]) begin
                iss[i] = (client_op[i] != OP_NOP);
                exp_l  = expect_result(client_op[i], client_al[i], client_bl[i], client_cl[i]);
                exp_r  = expect_result(client_op[i], client_ar[i], client_br[i], client_cr[i]);
            end
        end
    end

    assign held = (gnt == gnt_d) ? held_d + 1 : 1;

    always_ff @(posedge clk) begin
        if (rst) begin
            last_owner <= 1'b1;
            idle_win_q <= '0;
            gnt_d      <= '0;
            held_d     <= 0;
            for (int k = 0; k < 3; k++) begin
                iss_q[k]   <= '0;
                exp_l_q[k] <= '0;
                exp_r_q[k] <= '0;
            end
        end else begin
            if (gnt[0]) last_owner <= 1'b0;
            else if (gnt[1]) last_owner <= 1'b1;
            idle_win_q <= idle_win;
            gnt_d      <= gnt;
            held_d     <= held;
            iss_q[0]   <= iss;   // Three sample edges from issue to done.
            exp_l_q[0] <= exp_l;
            exp_r_q[0] <= exp_r;
            for (int k = 1; k < 3; k++) begin
                iss_q[k]   <= iss_q[k-1];
                exp_l_q[k] <= exp_l_q[k-1];
                exp_r_q[k] <= exp_r_q[k-1];
            end
        end
    end

    a_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(gnt))
        else begin
            fail_count++;
            $error("More than one grant bit is high at %0t: gnt %b", $time, $sampled(gnt));
        end

    a_idle: assert property (@(posedge clk) disable iff (rst) gnt == '0 |=> gnt == idle_win_q)
        else begin
            fail_count++;
            $error("MISMATCH time %0t gnt expected %b actual %b",
                   $time, $sampled(idle_win_q), $sampled(gnt));
        end

    for (genvar i = 0; i < CLIENTS_N; i++) begin : g_client
        localparam int O = 1 - i;  // The other client.

        a_reset: assert property (@(posedge clk) $fell(rst) |->
                !gnt[i] && !done[i] && client_pl[i] == '0 && client_pr[i] == '0)
            else begin
                fail_count++;
                $error("Client %0d outputs are not cleared by reset at %0t", i, $time);
            end

        a_keep: assert property (@(posedge clk) disable iff (rst)
                gnt[i] && req[i] && (!req[O] || held < QUANTUM) |=> gnt[i])
            else begin
                fail_count++;
                $error("MISMATCH time %0t gnt[%0d] expected 1 actual %b",
                       $time, i, $sampled(gnt[i]));
            end

        a_release: assert property (@(posedge clk) disable iff (rst)
                gnt[i] && !req[i] |=> !gnt[i])
            else begin
                fail_count++;
                $error("MISMATCH time %0t gnt[%0d] expected 0 actual %b",
                       $time, i, $sampled(gnt[i]));
            end

        a_rotate: assert property (@(posedge clk) disable iff (rst)
                gnt[i] && req[O] && (!req[i] || held >= QUANTUM) |=> gnt[O])
            else begin
                fail_count++;
                $error("MISMATCH time %0t gnt[%0d] expected 1 actual %b",
                       $time, O, $sampled(gnt[O]));
            end

        a_done: assert property (@(posedge clk) disable iff (rst) done[i] == iss_q[2][i])
            else begin
                fail_count++;
                $error("MISMATCH time %0t done[%0d] expected %b actual %b",
                       $time, i, $sampled(iss_q[2][i]), $sampled(done[i]));
            end

        a_left: assert property (@(posedge clk) disable iff (rst)
                done[i] |-> client_pl[i] == exp_l_q[2])
            else begin
                fail_count++;
                $error("MISMATCH time %0t client_pl[%0d] expected %h actual %h",
                       $time, i, $sampled(exp_l_q[2]), $sampled(client_pl[i]));
            end

        a_right: assert property (@(posedge clk) disable iff (rst)
                done[i] |-> client_pr[i] == exp_r_q[2])
            else begin
                fail_count++;
                $error("MISMATCH time %0t client_pr[%0d] expected %h actual %h",
                       $time, i, $sampled(exp_r_q[2]), $sampled(client_pr[i]));
            end
    end

endmodule

bind dsp_mul_top dsp_mul_asserts u_chk (.*);

/* testbench/dsp_mul_tb.sv */
/*
 * Testbench top for the DSP multiply subsystem: reset, seeded random
 * client traffic, bounded waits and the final verdict.
 */

`timescale 1ns/100ps

module dsp_mul_tb;
    import dsp_pkg::*;

    logic                   clk;
    logic                   rst;
    logic [CLIENTS_N-1:0]   req;
    logic [CLIENTS_N-1:0]   gnt;
    logic [CLIENTS_N-1:0]   done;
    logic        [OP_W-1:0] client_op [CLIENTS_N];
    logic signed [AB_W-1:0] client_al [CLIENTS_N];
    logic signed [AB_W-1:0] client_bl [CLIENTS_N];
    logic signed [AB_W-1:0] client_ar [CLIENTS_N];
    logic signed [AB_W-1:0] client_br [CLIENTS_N];
    logic signed [CP_W-1:0] client_cl [CLIENTS_N];
    logic signed [CP_W-1:0] client_cr [CLIENTS_N];
    logic signed [CP_W-1:0] client_pl [CLIENTS_N];
    logic signed [CP_W-1:0] client_pr [CLIENTS_N];
    logic        [OP_W-1:0] op_list [6];    // Every opcode plus an unknown one.

    tb_clock u_clk (.clk(clk));

    dsp_mul_top uut (.*);

    // Inputs change 10 ns after the rising edge.
    task automatic step();
        @(posedge clk);
        #10;
    endtask

    function automatic logic [AB_W-1:0] rand_ab();
        logic [31:0] r;

        r = $urandom;
        return r[AB_W-1:0];
    endfunction

    function automatic logic [CP_W-1:0] rand_cp();
        logic [63:0] r;

        r = {$urandom, $urandom};
        return r[CP_W-1:0];
    endfunction

    task automatic load_client(input int i, input logic [OP_W-1:0] op);
        client_op[i] = op;
        client_al[i] = rand_ab();
        client_bl[i] = rand_ab();
        client_ar[i] = rand_ab();
        client_br[i] = rand_ab();
        client_cl[i] = rand_cp();
        client_cr[i] = rand_cp();
    endtask

    task automatic clear_client(input int i);
        client_op[i] = OP_NOP;
        client_al[i] = '0;
        client_bl[i] = '0;
        client_ar[i] = '0;
        client_br[i] = '0;
        client_cl[i] = '0;
        client_cr[i] = '0;
    endtask

    task automatic stop_on_timeout(input string what);
        $display("Timeout while waiting for %s", what);
        $display("Something failed");
        $fatal(1, "Simulation stopped after a timeout");
    endtask

    task automatic wait_grant(input int i);
        int n;

        n = 0;
        while (!gnt[i] && n < 40) begin
            step();
            n++;
        end
        if (!gnt[i]) stop_on_timeout($sformatf("a grant to client %0d", i));
    endtask

    task automatic wait_idle();
        int n;

        n = 0;
        while (gnt != '0 && n < 40) begin
            step();
            n++;
        end
        if (gnt != '0) stop_on_timeout("the grant to be released");
    endtask

    task automatic wait_done(input int i);
        int n;

        n = 0;
        while (!done[i] && n < 40) begin
            step();
            n++;
        end
        if (!done[i]) stop_on_timeout($sformatf("done from client %0d", i));
    endtask

    // Stops the run at the first assertion failure.
    always @(negedge clk) begin
        if (uut.u_chk.fail_count != 0) begin
            $display("Something failed");
            $fatal(1, "An assertion on the DUT failed");
        end
    end

    initial begin
        rst = 1'b1;
        req = '0;
        for (int i = 0; i < CLIENTS_N; i++) clear_client(i);
        op_list = '{OP_MUL, OP_MAC, OP_MSU, OP_PASS, OP_NOP, 8'ha5};
        void'($urandom(32'hdeb3c353));
        repeat (2) @(posedge clk);
        #10;
        rst = 1'b0;

        // Both clients compete from reset, so grants rotate by quantum.
        req = 2'b11;
        wait_grant(0);
        repeat (24) begin
            for (int i = 0; i < CLIENTS_N; i++) load_client(i, op_list[$urandom_range(5, 0)]);
            step();
        end
        req = '0;
        clear_client(0);
        clear_client(1);
        wait_idle();

        // Each client alone runs through every opcode, client 1 first.
        for (int k = 1; k >= 0; k--) begin
            req[k] = 1'b1;
            wait_grant(k);
            foreach (op_list[j]) begin
                load_client(k, op_list[j]);
                step();
            end
            clear_client(k);
            wait_done(k);
            req[k] = 1'b0;
            wait_idle();
        end

        // Tie after client 0 owned last, client 0 presents an op ungranted.
        req = 2'b11;
        wait_grant(1);
        load_client(0, OP_MAC);
        load_client(1, OP_MSU);
        step();
        req = '0;
        clear_client(0);
        clear_client(1);
        wait_done(1);
        wait_idle();
        step();

        if (uut.u_chk.fail_count == 0) begin
            $display("Everything OK");
            $finish;
        end else begin
            $display("Something failed");
            $fatal(1, "Assertion errors were reported");
        end
    end

endmodule

/* dsp_mul_top.f */
source/dsp_pkg.sv
source/dsp_lane_if.sv
source/arb_rr.sv
source/grant_timer.sv
source/dsp_nic_mul.sv
source/dsp_slice.sv
source/dsp_mul_top.sv
testbench/tb_clock.sv
testbench/dsp_mul_asserts.sv
testbench/dsp_mul_tb.sv

/* Makefile */
# Verilator build and run, lint and clean for the shared DSP multiply subsystem.

TOP = dsp_mul_tb

all: run

obj_dir/V$(TOP): dsp_mul_top.f $(wildcard source/*.sv testbench/*.sv)
	verilator --binary --timing --assert -j 0 -f dsp_mul_top.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee sim.log
	grep -q "Everything OK" sim.log

lint:
	verilator --lint-only -Wall --top-module dsp_mul_top \
		source/dsp_pkg.sv source/dsp_lane_if.sv source/arb_rr.sv \
		source/grant_timer.sv source/dsp_nic_mul.sv source/dsp_slice.sv \
		source/dsp_mul_top.sv

clean:
	rm -rf obj_dir sim.log

.PHONY: all run lint clean
